//--- sources.f
eth_tx_pkg.sv
eth_onehot.sv
eth_tx_source.sv
eth_tx_mux.sv
eth_tx_mac_sink.sv
eth_tx_top.sv
tb_eth_tx.sv

//--- Bender.yml
package:
  name: eth_tx

sources:
  - eth_tx_pkg.sv
  - eth_onehot.sv
  - eth_tx_source.sv
  - eth_tx_mux.sv
  - eth_tx_mac_sink.sv
  - eth_tx_top.sv
  - target: test
    files:
      - tb_eth_tx.sv

//--- tb_eth_tx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eth_tx
  import eth_tx_pkg::*;
();

  localparam int N       = 3;
  localparam int W       = 8;
  localparam int MAX_LEN = 64;
  // about 20 frames of at most ~100 cycles each, times ten for margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int WAIT_LIMIT     = 500;

  logic                clk;
  logic                rst;
  logic [N-1:0]        cmd_val;
  wire  [N-1:0]        cmd_rdy;
  len_t [N-1:0]        cmd_len;
  logic [N-1:0][W-1:0] cmd_meta;
  byte_t [N-1:0]       cmd_base;
  wire  byte_t         tx_dat;
  wire                 tx_val;
  wire                 rep_val;
  wire  [W-1:0]        rep_meta;
  wire  len_t          rep_len;
  wire  sum_t          rep_sum;
  wire                 rep_err;

  logic [W-1:0] got_meta[$];  // reports as they arrive
  len_t         got_len[$];
  sum_t         got_sum[$];
  logic         got_err[$];
  byte_t        tx_q[$];      // stream bytes as they pass
  int           errors;
  int           tests_run;
  int           tests_failed;
  int           tx_bytes;
  int           cycles = 0;
  logic [31:0]  rng;

  eth_tx_top #(
    .N       (N),
    .W       (W),
    .MAX_LEN (MAX_LEN)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .cmd_val  (cmd_val),
    .cmd_rdy  (cmd_rdy),
    .cmd_len  (cmd_len),
    .cmd_meta (cmd_meta),
    .cmd_base (cmd_base),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val),
    .rep_val  (rep_val),
    .rep_meta (rep_meta),
    .rep_len  (rep_len),
    .rep_sum  (rep_sum),
    .rep_err  (rep_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    if (rep_val) begin
      got_meta.push_back(rep_meta);
      got_len.push_back(rep_len);
      got_sum.push_back(rep_sum);
      got_err.push_back(rep_err);
    end
    if (tx_val) begin
      tx_bytes++;
      tx_q.push_back(tx_dat);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic byte_t next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng[23:16];
  endfunction

  // payload byte k is base + k, sum taken modulo 256
  function automatic sum_t expect_sum(byte_t base, int n);
    int acc;
    acc = 0;
    for (int k = 0; k < n; k++) acc += (base + k) % 256;
    return sum_t'(acc % 256);
  endfunction

  task automatic check_meta(string name, logic [W-1:0] exp, logic [W-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s meta: expected 0x%02h, actual 0x%02h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_len(string name, len_t exp, len_t act);
    if (act !== exp) begin
      $display("[FAIL] %s len: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_sum(string name, sum_t exp, sum_t act);
    if (act !== exp) begin
      $display("[FAIL] %s sum: expected 0x%02h, actual 0x%02h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(string name, byte_t exp, byte_t act);
    if (act !== exp) begin
      $display("[FAIL] %s tx_dat: expected 0x%02h, actual 0x%02h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_cmd_rdy(int src, string name);
    int n;
    n = 0;
    while (!cmd_rdy[src] && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!cmd_rdy[src]) begin
      $display("%s: source %0d never became free for a command", name, src);
      errors++;
    end
  endtask

  task automatic wait_stream(string name);
    int n;
    n = 0;
    while (!tx_val && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (!tx_val) begin
      $display("%s: the stream never started", name);
      errors++;
    end
  endtask

  task automatic wait_reports(int count, string name);
    int n;
    n = 0;
    while (got_meta.size() < count && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (got_meta.size() < count) begin
      $display("%s: timed out waiting for %0d frame reports", name, count);
      errors++;
    end
  endtask

  task automatic load_cmd(int src, len_t len, logic [W-1:0] meta, byte_t base);
    cmd_val[src]  = 1'b1;
    cmd_len[src]  = len;
    cmd_meta[src] = meta;
    cmd_base[src] = base;
  endtask

  task automatic send_cmd(int src, len_t len, logic [W-1:0] meta, byte_t base);
    load_cmd(src, len, meta, base);
    tick();
    cmd_val = '0;
  endtask

  // oversize frames are cut after MAX_LEN + 1 bytes
  task automatic expect_report(string name, logic [W-1:0] meta, len_t len, byte_t base);
    len_t n;
    n = (len > MAX_LEN) ? len_t'(MAX_LEN + 1) : len;
    if (got_meta.size() == 0) begin
      $display("%s: no frame report left to check", name);
      errors++;
    end else begin
      check_meta(name, meta, got_meta.pop_front());
      check_len(name, n, got_len.pop_front());
      check_sum(name, expect_sum(base, n), got_sum.pop_front());
      check_bit({name, " rep_err"}, len > MAX_LEN, got_err.pop_front());
    end
  endtask

  // bytes seen on tx_dat since the last call, byte k is base + k
  task automatic check_stream(string name, len_t len, byte_t base);
    check_len({name, " stream bytes"}, len, len_t'(tx_q.size()));
    for (int k = 0; k < len && tx_q.size() > 0; k++) begin
      check_byte(name, byte_t'(base + k), tx_q.pop_front());
    end
    tx_q.delete();
  endtask

  task automatic run_frame(string name, int src, len_t len, logic [W-1:0] meta, byte_t base);
    wait_cmd_rdy(src, name);
    send_cmd(src, len, meta, base);
    wait_reports(1, name);
    expect_report(name, meta, len, base);
  endtask

  task automatic finish_test(string name, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_single();
    int e;
    e = errors;
    check_bit("cmd_rdy after reset", 1'b1, &cmd_rdy);
    run_frame("single src0", 0, 1, 8'h10, next_rand());
    run_frame("single src1", 1, 7, 8'h11, next_rand());
    run_frame("single src2", 2, 64, 8'h12, next_rand());
    finish_test("single frames", e);
  endtask

  task automatic test_priority();
    int    e;
    byte_t b [N];
    e = errors;
    for (int s = 0; s < N; s++) wait_cmd_rdy(s, "priority");
    for (int s = 0; s < N; s++) begin
      b[s] = next_rand();
      load_cmd(s, len_t'(3 + s), W'(8'h20 + s), b[s]);
    end
    tick();
    cmd_val = '0;
    wait_reports(N, "priority");
    // highest index first
    for (int s = N - 1; s >= 0; s--) begin
      expect_report("priority", W'(8'h20 + s), len_t'(3 + s), b[s]);
    end
    finish_test("priority", e);
  endtask

  task automatic test_late();
    int    e;
    byte_t b0;
    byte_t b2;
    e  = errors;
    b0 = next_rand();
    b2 = next_rand();
    wait_cmd_rdy(0, "late");
    wait_cmd_rdy(2, "late");
    send_cmd(0, 40, 8'h30, b0);
    wait_stream("late");
    send_cmd(2, 5, 8'h32, b2);  // arrives mid-frame
    wait_reports(2, "late");
    expect_report("late src0", 8'h30, 40, b0);
    expect_report("late src2", 8'h32, 5, b2);
    finish_test("late request", e);
  endtask

  task automatic test_oversize();
    int e;
    e = errors;
    run_frame("oversize", 1, 80, 8'h40, next_rand());
    wait_cmd_rdy(1, "oversize");
    finish_test("oversize", e);
  endtask

  task automatic test_random();
    int    e;
    int    src;
    int    total;
    len_t  len;
    byte_t base;
    e        = errors;
    total    = 0;
    tx_bytes = 0;
    tx_q.delete();
    for (int j = 0; j < 10; j++) begin
      src  = next_rand() % N;
      len  = len_t'(next_rand() % MAX_LEN + 1);
      base = next_rand();
      run_frame("random", src, len, W'(8'h50 + j), base);
      check_stream("random", len, base);
      total += len;
    end
    check_len("random tx_val bytes", len_t'(total), len_t'(tx_bytes));
    finish_test("random frames", e);
  endtask

  initial begin
    rng          = 32'd48377;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    tx_bytes     = 0;
    rst          = 1'b1;
    cmd_val      = '0;
    cmd_len      = '0;
    cmd_meta     = '0;
    cmd_base     = '0;
    repeat (4) @(posedge clk);
    #5;
    rst = 1'b0;
    test_single();
    test_priority();
    test_late();
    test_oversize();
    test_random();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- eth_tx_top.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx_top
  import eth_tx_pkg::*;
#(
  parameter int N       = 3,
  parameter int W       = 8,
  parameter int MAX_LEN = 64
) (
  input  wire                 clk,
  input  wire                 rst,
  // frame commands, one lane per source
  input  wire  [N-1:0]        cmd_val,
  output wire  [N-1:0]        cmd_rdy,
  input  wire  len_t [N-1:0]  cmd_len,
  input  wire  [N-1:0][W-1:0] cmd_meta,
  input  wire  byte_t [N-1:0] cmd_base,
  // MAC-side stream copy
  output wire  byte_t         tx_dat,
  output wire                 tx_val,
  // per-frame report
  output wire                 rep_val,
  output wire  [W-1:0]        rep_meta,
  output wire  len_t          rep_len,
  output wire  sum_t          rep_sum,
  output wire                 rep_err
);

  wire [N-1:0]         rdy, req, acc, err, done;
  wire [N-1:0][W-1:0]  meta;
  wire byte_t [N-1:0]  dat;
  wire [N-1:0]         val, sof, eof;

  wire                 rdy_mux, req_mux, acc_mux, err_mux, done_mux;
  wire [W-1:0]         meta_mux;
  wire byte_t          dat_mux;
  wire                 val_mux, sof_mux, eof_mux;

  assign tx_dat = dat_mux;
  assign tx_val = val_mux;

  for (genvar i = 0; i < N; i++) begin : gen_src
    eth_tx_source #(
      .W (W)
    ) source_i (
      .clk      (clk),
      .rst      (rst),
      .cmd_val  (cmd_val[i]),
      .cmd_rdy  (cmd_rdy[i]),
      .cmd_len  (cmd_len[i]),
      .cmd_meta (cmd_meta[i]),
      .cmd_base (cmd_base[i]),
      .rdy      (rdy[i]),
      .req      (req[i]),
      .acc      (acc[i]),
      .err      (err[i]),
      .done     (done[i]),
      .meta     (meta[i]),
      .dat      (dat[i]),
      .val      (val[i]),
      .sof      (sof[i]),
      .eof      (eof[i])
    );
  end

  eth_tx_mux #(
    .N (N),
    .W (W)
  ) mux_i (
    .clk      (clk),
    .rst      (rst),
    .rdy      (rdy),
    .req      (req),
    .acc      (acc),
    .err      (err),
    .done     (done),
    .meta     (meta),
    .dat      (dat),
    .val      (val),
    .sof      (sof),
    .eof      (eof),
    .rdy_mux  (rdy_mux),
    .req_mux  (req_mux),
    .acc_mux  (acc_mux),
    .err_mux  (err_mux),
    .done_mux (done_mux),
    .meta_mux (meta_mux),
    .dat_mux  (dat_mux),
    .val_mux  (val_mux),
    .sof_mux  (sof_mux),
    .eof_mux  (eof_mux)
  );

  eth_tx_mac_sink #(
    .W       (W),
    .MAX_LEN (MAX_LEN)
  ) sink_i (
    .clk      (clk),
    .rst      (rst),
    .rdy_mux  (rdy_mux),
    .req_mux  (req_mux),
    .acc_mux  (acc_mux),
    .err_mux  (err_mux),
    .done_mux (done_mux),
    .meta_mux (meta_mux),
    .dat_mux  (dat_mux),
    .val_mux  (val_mux),
    .sof_mux  (sof_mux),
    .eof_mux  (eof_mux),
    .rep_val  (rep_val),
    .rep_meta (rep_meta),
    .rep_len  (rep_len),
    .rep_sum  (rep_sum),
    .rep_err  (rep_err)
  );

endmodule

`default_nettype wire

//--- eth_tx_mac_sink.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx_mac_sink
  import eth_tx_pkg::*;
#(
  parameter int W       = 8,
  parameter int MAX_LEN = 64
) (
  input  wire          clk,
  input  wire          rst,
  // from mux
  input  wire          rdy_mux,
  output logic         req_mux,
  output logic         acc_mux,
  output logic         err_mux,
  output logic         done_mux,
  input  wire  [W-1:0] meta_mux,
  input  wire  byte_t  dat_mux,
  input  wire          val_mux,
  input  wire          sof_mux,
  input  wire          eof_mux,
  // frame report
  output logic         rep_val,
  output logic [W-1:0] rep_meta,
  output len_t         rep_len,
  output sum_t         rep_sum,
  output logic         rep_err
);

  sink_state_t  state;
  len_t         cnt;
  sum_t         sum;
  logic [W-1:0] meta_q;
  len_t         cnt_nxt;
  sum_t         sum_nxt;
  logic [W-1:0] meta_cur;
  logic         over;

  assign cnt_nxt  = cnt + len_t'(1);
  assign sum_nxt  = sum + dat_mux;
  assign meta_cur = sof_mux ? meta_mux : meta_q; // single-byte frames
  assign over     = (cnt == len_t'(MAX_LEN));    // this byte is one too many

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= snk_idle;
      req_mux  <= 1'b0;
      acc_mux  <= 1'b0;
      err_mux  <= 1'b0;
      done_mux <= 1'b0;
      rep_val  <= 1'b0;
    end else begin
      req_mux  <= 1'b0;
      acc_mux  <= 1'b0;
      err_mux  <= 1'b0;
      done_mux <= 1'b0;
      rep_val  <= 1'b0;
      case (state)
        snk_idle: begin
          if (rdy_mux) begin
            req_mux <= 1'b1;
            state   <= snk_req;
          end
        end
        snk_req: begin
          acc_mux <= 1'b1;
          state   <= snk_acc;
        end
        snk_acc: begin
          cnt   <= '0;
          sum   <= '0;
          state <= snk_recv;
        end
        snk_recv: begin
          if (val_mux) begin
            if (sof_mux) meta_q <= meta_mux;
            cnt <= cnt_nxt;
            sum <= sum_nxt;
            if (over || eof_mux) begin
              err_mux  <= over;
              done_mux <= !over;
              rep_val  <= 1'b1;
              rep_meta <= meta_cur;
              rep_len  <= cnt_nxt;
              rep_sum  <= sum_nxt;
              rep_err  <= over;
              state    <= snk_report;
            end
          end
        end
        snk_report: state <= snk_idle; // lets the mux drop back to idle
        default:    state <= snk_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- eth_tx_mux.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx_mux
  import eth_tx_pkg::*;
#(
  parameter int N = 3,
  parameter int W = 8
) (
  input  wire                  clk,
  input  wire                  rst,
  // source side
  input  wire  [N-1:0]         rdy,
  output logic [N-1:0]         req,
  output logic [N-1:0]         acc,
  output logic [N-1:0]         err,
  output logic [N-1:0]         done,
  input  wire  [N-1:0][W-1:0]  meta,
  input  wire  byte_t [N-1:0]  dat,
  input  wire  [N-1:0]         val,
  input  wire  [N-1:0]         sof,
  input  wire  [N-1:0]         eof,
  // sink side
  output logic                 rdy_mux,
  input  wire                  req_mux,
  input  wire                  acc_mux,
  input  wire                  err_mux,
  input  wire                  done_mux,
  output logic [W-1:0]         meta_mux,
  output byte_t                dat_mux,
  output logic                 val_mux,
  output logic                 sof_mux,
  output logic                 eof_mux
);

  localparam int IW = (N > 1) ? $clog2(N) : 1;

  mux_state_t    state;
  logic [N-1:0]  cur_rdy;  // rdy as sampled when leaving idle
  logic [N-1:0]  grant;
  logic [IW-1:0] ind;

  eth_onehot #(
    .N (N)
  ) onehot_i (
    .i (cur_rdy),
    .o (grant)
  );

  always_comb begin
    ind = '0;
    for (int k = 0; k < N; k++) begin
      if (grant[k]) ind = IW'(k);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= mux_idle;
      cur_rdy <= '0;
      rdy_mux <= 1'b0;
      val_mux <= 1'b0;
      sof_mux <= 1'b0;
      eof_mux <= 1'b0;
    end else begin
      case (state)
        mux_idle: begin
          val_mux <= 1'b0;
          sof_mux <= 1'b0;
          eof_mux <= 1'b0;
          // grant is kept until a new request so late replies still route
          if (|rdy) begin
            cur_rdy <= rdy;
            state   <= mux_active;
          end
        end
        mux_active: begin
          if (eof_mux || err_mux) begin
            state   <= mux_idle;
            rdy_mux <= 1'b0;
            val_mux <= 1'b0;
            sof_mux <= 1'b0;
            eof_mux <= 1'b0;
          end else begin
            val_mux <= val[ind];
            sof_mux <= sof[ind];
            eof_mux <= eof[ind];
            rdy_mux <= val_mux ? 1'b0 : |(grant & rdy); // drop once data flows
          end
        end
        default: state <= mux_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mux_active) begin
      meta_mux <= meta[ind];
      dat_mux  <= dat[ind];
    end
  end

  // replies only go to the granted source
  always_ff @(posedge clk) begin
    if (rst) begin
      req  <= '0;
      acc  <= '0;
      err  <= '0;
      done <= '0;
    end else begin
      req  <= grant & {N{req_mux}};
      acc  <= grant & {N{acc_mux}};
      err  <= grant & {N{err_mux}};
      done <= grant & {N{done_mux}};
    end
  end

endmodule

`default_nettype wire

//--- eth_tx_source.sv
`timescale 1ns/1ns
`default_nettype none

module eth_tx_source
  import eth_tx_pkg::*;
#(
  parameter int W = 8
) (
  input  wire          clk,
  input  wire          rst,
  // frame command
  input  wire          cmd_val,
  output logic         cmd_rdy,
  input  wire  len_t   cmd_len,
  input  wire  [W-1:0] cmd_meta,
  input  wire  byte_t  cmd_base,
  // to mux
  output logic         rdy,
  input  wire          req,
  input  wire          acc,
  input  wire          err,
  input  wire          done,
  output logic [W-1:0] meta,
  output byte_t        dat,
  output logic         val,
  output logic         sof,
  output logic         eof
);

  src_state_t state;
  len_t       len_q;
  len_t       cnt;      // index of the next byte
  logic       granted;  // req seen for this frame

  assign cmd_rdy = (state == src_idle);
  // an abort pulse hides rdy so the mux does not regrant this frame
  assign rdy = (state == src_wait || state == src_send) && !err;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= src_idle;
      granted <= 1'b0;
      val     <= 1'b0;
      sof     <= 1'b0;
      eof     <= 1'b0;
    end else begin
      case (state)
        src_idle: begin
          granted <= 1'b0;
          if (cmd_val) begin
            len_q <= cmd_len;
            meta  <= cmd_meta;
            dat   <= cmd_base; // payload byte 0
            state <= src_wait;
          end
        end
        src_wait: begin
          if (req) granted <= 1'b1;
          if (err) begin
            state <= src_idle;
          end else if (acc && (granted || req)) begin
            val   <= 1'b1;
            sof   <= 1'b1;
            eof   <= (len_q == len_t'(1));
            cnt   <= len_t'(1);
            state <= src_send;
          end
        end
        src_send: begin
          if (err || eof) begin
            val   <= 1'b0;
            sof   <= 1'b0;
            eof   <= 1'b0;
            state <= err ? src_idle : src_end;
          end else begin
            dat <= dat + byte_t'(1);
            sof <= 1'b0;
            eof <= (cnt == len_q - len_t'(1));
            cnt <= cnt + len_t'(1);
          end
        end
        src_end: begin
          if (done || err) state <= src_idle; // wait for sink verdict
        end
        default: state <= src_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- eth_onehot.sv
`timescale 1ns/1ns
`default_nettype none

// keeps only the most significant set bit
module eth_onehot #(
  parameter int N = 3
) (
  input  wire  [N-1:0] i,
  output logic [N-1:0] o
);

  always_comb begin
    o = '0;
    // later (higher) bits overwrite lower ones
    for (int k = 0; k < N; k++) begin
      if (i[k]) begin
        o    = '0;
        o[k] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

  typedef logic [7:0]  byte_t;  // one stream byte
  typedef logic [10:0] len_t;   // frame length, up to 2047
  typedef logic [7:0]  sum_t;   // payload sum modulo 256

  // per-protocol frame holder
  typedef enum logic [1:0] {
    src_idle,
    src_wait,
    src_send,
    src_end
  } src_state_t;

  typedef enum logic {
    mux_idle,
    mux_active
  } mux_state_t;

  // MAC-side consumer
  typedef enum logic [2:0] {
    snk_idle,
    snk_req,
    snk_acc,
    snk_recv,
    snk_report
  } sink_state_t;

endpackage

`default_nettype wire
